//--- rtl/uf_pkg.sv
package uf_pkg;

    localparam int STAGE_WIDTH = 3;

    typedef enum logic [STAGE_WIDTH-1:0] {
        STAGE_IDLE               = 3'd0,
        STAGE_MEASUREMENT_LOADING = 3'd1,
        STAGE_GROW               = 3'd2,
        STAGE_MERGE              = 3'd3,
        STAGE_RESULT_CALCULATING = 3'd4
    } uf_stage_t;

    // growth of one edge, saturates at full
    typedef enum logic [1:0] {
        GROWTH_EMPTY = 2'd0,
        GROWTH_HALF  = 2'd1,
        GROWTH_FULL  = 2'd2
    } growth_t;

    localparam int APB_ADDR_WIDTH = 8;

    // register map
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL       = 8'h00; // bit 0 start, write only
    localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS     = 8'h04; // bit 0 busy, bit 1 done
    localparam logic [APB_ADDR_WIDTH-1:0] REG_SYNDROME   = 8'h08;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_ITERATIONS = 8'h0C;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CYCLES     = 8'h10;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_ERASURE    = 8'h14;

endpackage

//--- rtl/uf_processing_unit.sv
module uf_processing_unit #(
    parameter bit HAS_RIGHT_BOUNDARY = 1'b0
) (
    input  logic              clk,
    input  logic              reset,
    input  uf_pkg::uf_stage_t global_stage,
    input  logic              syndrome_bit,
    input  logic              odd_left_neighbor,
    input  logic              odd_right_neighbor,
    input  logic              lparity_in,
    input  logic              lbound_in,
    input  logic              rparity_in,
    input  logic              rbound_in,
    input  logic              edge_right_full,
    output logic              odd,
    output logic              busy,
    output logic              lparity,
    output logic              lbound,
    output logic              rparity,
    output logic              rbound,
    output logic              edge_left_full,
    output logic              boundary_edge_full
);
    import uf_pkg::*;

    logic    defect;
    growth_t left_growth;
    logic    lp_q, lb_q, rp_q, rb_q; // parity / boundary seen from each side, self excluded
    logic    lp_d, lb_d, rp_d, rb_d;

    function automatic growth_t grow_edge(growth_t g, logic side_a, logic side_b);
        logic [2:0] sum;
        sum = 3'(g) + 3'(side_a) + 3'(side_b);
        return (sum >= 3'(GROWTH_FULL)) ? GROWTH_FULL : growth_t'(sum[1:0]);
    endfunction

    assign edge_left_full = (left_growth == GROWTH_FULL);

    assign lparity = lp_q ^ defect;
    assign lbound  = lb_q;
    assign rparity = rp_q ^ defect;
    assign rbound  = rb_q;

    assign odd = (lp_q ^ rp_q ^ defect) & ~lb_q & ~rb_q;

    // one hop per cycle, only across full edges
    assign lp_d = edge_left_full & lparity_in;
    assign lb_d = edge_left_full & lbound_in;
    assign rp_d = edge_right_full & rparity_in;
    assign rb_d = edge_right_full & rbound_in;

    assign busy = (global_stage == STAGE_MERGE) &&
                  ({lp_d, lb_d, rp_d, rb_d} != {lp_q, lb_q, rp_q, rb_q});

    always_ff @(posedge clk) begin
        if (reset) begin
            defect      <= 1'b0;
            left_growth <= GROWTH_EMPTY;
            {lp_q, lb_q, rp_q, rb_q} <= '0;
        end else begin
            case (global_stage)
                STAGE_MEASUREMENT_LOADING: begin
                    defect      <= syndrome_bit;
                    left_growth <= GROWTH_EMPTY;
                    {lp_q, lb_q, rp_q, rb_q} <= '0;
                end
                STAGE_GROW: left_growth <= grow_edge(left_growth, odd_left_neighbor, odd);
                STAGE_MERGE: {lp_q, lb_q, rp_q, rb_q} <= {lp_d, lb_d, rp_d, rb_d};
                default: ;
            endcase
        end
    end

    if (HAS_RIGHT_BOUNDARY) begin : g_right_boundary
        growth_t right_growth;

        // outer neighbor is tied low by the array
        always_ff @(posedge clk) begin
            if (reset || global_stage == STAGE_MEASUREMENT_LOADING) begin
                right_growth <= GROWTH_EMPTY;
            end else if (global_stage == STAGE_GROW) begin
                right_growth <= grow_edge(right_growth, odd, odd_right_neighbor);
            end
        end

        assign boundary_edge_full = (right_growth == GROWTH_FULL);

        right_growth_bounded: assert property (
            @(posedge clk) disable iff (reset) right_growth <= GROWTH_FULL
        ) else $error("boundary edge grew past full");
    end else begin : g_no_boundary
        assign boundary_edge_full = 1'b0;
    end

    left_growth_bounded: assert property (
        @(posedge clk) disable iff (reset) left_growth <= GROWTH_FULL
    ) else $error("left edge grew past full");

endmodule

//--- rtl/uf_pu_array.sv
module uf_pu_array #(
    parameter int PU_COUNT = 18
) (
    input  logic              clk,
    input  logic              reset,
    input  uf_pkg::uf_stage_t global_stage,
    input  logic [PU_COUNT-1:0] syndrome,
    output logic [PU_COUNT-1:0] busy_pe,
    output logic [PU_COUNT-1:0] odd_clusters_pe,
    output logic [PU_COUNT:0]   erasure
);

    logic [PU_COUNT+1:0] odd_ext;   // padded with a zero at each end
    logic [PU_COUNT-1:0] lparity;
    logic [PU_COUNT-1:0] lbound;
    logic [PU_COUNT-1:0] rparity;
    logic [PU_COUNT-1:0] rbound;
    logic [PU_COUNT-1:0] boundary_full;

    assign odd_ext = {1'b0, odd_clusters_pe, 1'b0};

    // only the last unit drives a boundary edge
    assign erasure[PU_COUNT] = |boundary_full;

    for (genvar i = 0; i < PU_COUNT; i++) begin : g_pu
        logic lparity_in, lbound_in, rparity_in, rbound_in, edge_right_full;

        if (i == 0) begin : g_left_end
            assign lparity_in = 1'b0;
            assign lbound_in  = erasure[0]; // left boundary edge
        end else begin : g_left_link
            assign lparity_in = lparity[i-1];
            assign lbound_in  = lbound[i-1];
        end

        if (i == PU_COUNT - 1) begin : g_right_end
            assign rparity_in      = 1'b0;
            assign rbound_in       = erasure[PU_COUNT];
            assign edge_right_full = erasure[PU_COUNT];
        end else begin : g_right_link
            assign rparity_in      = rparity[i+1];
            assign rbound_in       = rbound[i+1];
            assign edge_right_full = erasure[i+1];
        end

        uf_processing_unit #(
            .HAS_RIGHT_BOUNDARY(i == PU_COUNT - 1)
        ) uf_processing_unit_i (
            .clk               (clk),
            .reset             (reset),
            .global_stage      (global_stage),
            .syndrome_bit      (syndrome[i]),
            .odd_left_neighbor (odd_ext[i]),
            .odd_right_neighbor(odd_ext[i+2]),
            .lparity_in        (lparity_in),
            .lbound_in         (lbound_in),
            .rparity_in        (rparity_in),
            .rbound_in         (rbound_in),
            .edge_right_full   (edge_right_full),
            .odd               (odd_clusters_pe[i]),
            .busy              (busy_pe[i]),
            .lparity           (lparity[i]),
            .lbound            (lbound[i]),
            .rparity           (rparity[i]),
            .rbound            (rbound[i]),
            .edge_left_full    (erasure[i]),
            .boundary_edge_full(boundary_full[i])
        );
    end

endmodule

//--- rtl/uf_controller.sv
module uf_controller #(
    parameter int PU_COUNT = 18,
    parameter int ITERATION_COUNTER_WIDTH = 8,
    parameter int MAXIMUM_DELAY = 1
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               new_round_start,
    input  logic [PU_COUNT-1:0]                busy_pe,
    input  logic [PU_COUNT-1:0]                odd_clusters_pe,
    output uf_pkg::uf_stage_t                  global_stage,
    output logic                               results_valid,
    output logic [ITERATION_COUNTER_WIDTH-1:0] iteration_counter,
    output logic [31:0]                        cycle_counter
);
    import uf_pkg::*;

    localparam int DELAY_WIDTH = (MAXIMUM_DELAY > 0) ? $clog2(MAXIMUM_DELAY + 1) : 1;

    logic                   busy;
    logic                   odd_clusters;
    logic [DELAY_WIDTH-1:0] delay_counter;

    // flags arrive one cycle late
    always_ff @(posedge clk) begin
        if (reset) begin
            busy         <= 1'b0;
            odd_clusters <= 1'b0;
        end else begin
            busy         <= |busy_pe;
            odd_clusters <= |odd_clusters_pe;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_counter <= '0;
        end else if (global_stage == STAGE_MEASUREMENT_LOADING) begin
            cycle_counter <= 32'd1;
        end else if (!results_valid && global_stage != STAGE_IDLE) begin
            cycle_counter <= cycle_counter + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_counter <= '0;
        end else if (global_stage == STAGE_MEASUREMENT_LOADING) begin
            iteration_counter <= '0;
        end else if (global_stage == STAGE_GROW) begin
            iteration_counter <= iteration_counter + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            global_stage  <= STAGE_IDLE;
            delay_counter <= '0;
            results_valid <= 1'b0;
        end else begin
            case (global_stage)
                STAGE_IDLE: begin
                    if (new_round_start) begin
                        global_stage  <= STAGE_MEASUREMENT_LOADING;
                        delay_counter <= '0;
                        results_valid <= 1'b0;
                    end
                end
                STAGE_MEASUREMENT_LOADING: begin // single cycle
                    global_stage  <= STAGE_GROW;
                    delay_counter <= '0;
                end
                STAGE_GROW: begin
                    global_stage  <= STAGE_MERGE;
                    delay_counter <= '0;
                end
                STAGE_MERGE: begin
                    if (delay_counter >= DELAY_WIDTH'(MAXIMUM_DELAY)) begin
                        if (!busy) begin
                            global_stage  <= odd_clusters ? STAGE_GROW : STAGE_RESULT_CALCULATING;
                            delay_counter <= '0;
                        end
                    end else begin
                        delay_counter <= delay_counter + 1'b1;
                    end
                end
                STAGE_RESULT_CALCULATING: begin
                    global_stage  <= STAGE_IDLE;
                    results_valid <= 1'b1;
                end
                default: global_stage <= STAGE_IDLE;
            endcase
        end
    end

    stage_legal: assert property (
        @(posedge clk) disable iff (reset) global_stage <= STAGE_RESULT_CALCULATING
    ) else $error("illegal stage %0d", global_stage);

    // done only after a result stage
    valid_after_result: assert property (
        @(posedge clk) disable iff (reset)
        $rose(results_valid) |-> $past(global_stage) == STAGE_RESULT_CALCULATING
    ) else $error("results_valid rose outside result stage");

endmodule

//--- rtl/uf_apb_regs.sv
module uf_apb_regs #(
    parameter int PU_COUNT = 18,
    parameter int ITERATION_COUNTER_WIDTH = 8
) (
    input  logic                              clk,
    input  logic                              reset,

    input  logic [uf_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,

    output logic                              new_round_start,
    output logic [PU_COUNT-1:0]               syndrome,

    input  uf_pkg::uf_stage_t                 global_stage,
    input  logic                              results_valid,
    input  logic [ITERATION_COUNTER_WIDTH-1:0] iteration_counter,
    input  logic [31:0]                       cycle_counter,
    input  logic [PU_COUNT:0]                 erasure
);
    import uf_pkg::*;

    logic        access;
    logic        wr_en;
    logic        rd_en;
    logic        stage_busy;
    logic        addr_hit;
    logic [31:0] rd_data;

    assign access     = psel & penable;
    assign wr_en      = access & pwrite;
    assign rd_en      = access & ~pwrite;
    assign stage_busy = (global_stage != STAGE_IDLE);

    // read mux, also flags unknown offsets
    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (paddr)
            REG_CTRL:       rd_data = '0; // start reads back as zero
            REG_STATUS:     rd_data = {30'd0, results_valid, stage_busy};
            REG_SYNDROME:   rd_data = 32'(syndrome);
            REG_ITERATIONS: rd_data = 32'(iteration_counter);
            REG_CYCLES:     rd_data = cycle_counter;
            REG_ERASURE:    rd_data = 32'(erasure);
            default:        addr_hit = 1'b0;
        endcase
    end

    assign prdata  = rd_en ? rd_data : '0;
    assign pready  = 1'b1; // no wait states
    assign pslverr = access & ~addr_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            new_round_start <= 1'b0;
            syndrome        <= '0;
        end else begin
            // start only taken while idle
            new_round_start <= wr_en && (paddr == REG_CTRL) && pwdata[0] && !stage_busy;
            if (wr_en && (paddr == REG_SYNDROME) && !stage_busy) begin
                syndrome <= pwdata[PU_COUNT-1:0];
            end
        end
    end

    apb_penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset) penable |-> psel
    ) else $error("penable high without psel");

endmodule

//--- rtl/uf_decoder_top.sv
module uf_decoder_top #(
    parameter int CODE_DISTANCE_X = 3,
    parameter int CODE_DISTANCE_Z = 2,
    parameter int ITERATION_COUNTER_WIDTH = 8,
    parameter int MAXIMUM_DELAY = 1
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [uf_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr
);
    import uf_pkg::*;

    localparam int MEASUREMENT_ROUNDS =
        (CODE_DISTANCE_X > CODE_DISTANCE_Z) ? CODE_DISTANCE_X : CODE_DISTANCE_Z;
    localparam int PU_COUNT = CODE_DISTANCE_X * CODE_DISTANCE_Z * MEASUREMENT_ROUNDS;

    uf_stage_t                        global_stage;
    logic                             new_round_start;
    logic                             results_valid;
    logic [ITERATION_COUNTER_WIDTH-1:0] iteration_counter;
    logic [31:0]                      cycle_counter;
    logic [PU_COUNT-1:0]              syndrome;
    logic [PU_COUNT-1:0]              busy_pe;
    logic [PU_COUNT-1:0]              odd_clusters_pe;
    logic [PU_COUNT:0]                erasure;

    uf_apb_regs #(
        .PU_COUNT               (PU_COUNT),
        .ITERATION_COUNTER_WIDTH(ITERATION_COUNTER_WIDTH)
    ) uf_apb_regs_i (
        .clk, .reset,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .new_round_start, .syndrome,
        .global_stage, .results_valid, .iteration_counter, .cycle_counter, .erasure
    );

    uf_controller #(
        .PU_COUNT               (PU_COUNT),
        .ITERATION_COUNTER_WIDTH(ITERATION_COUNTER_WIDTH),
        .MAXIMUM_DELAY          (MAXIMUM_DELAY)
    ) uf_controller_i (
        .clk, .reset, .new_round_start, .busy_pe, .odd_clusters_pe,
        .global_stage, .results_valid, .iteration_counter, .cycle_counter
    );

    uf_pu_array #(
        .PU_COUNT(PU_COUNT)
    ) uf_pu_array_i (
        .clk, .reset, .global_stage, .syndrome, .busy_pe, .odd_clusters_pe, .erasure
    );

    // syndrome and erasure share one 32-bit register each
    pu_count_fits: assert property (@(posedge clk) PU_COUNT <= 31)
        else $error("PU_COUNT %0d exceeds register width", PU_COUNT);

endmodule

//--- dv/uf_decoder_tb.sv
module uf_decoder_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import uf_pkg::*;

    localparam int PU_COUNT = 18;
    localparam int MAXIMUM_DELAY = 1;
    localparam int ROUNDS = 48;
    localparam int WATCHDOG_CYCLES = ROUNDS * 200 + 2000;

    logic        clk;
    logic        reset;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] lcg_state;

    uf_decoder_top #(
        .CODE_DISTANCE_X        (3),
        .CODE_DISTANCE_Z        (2),
        .ITERATION_COUNTER_WIDTH(8),
        .MAXIMUM_DELAY          (MAXIMUM_DELAY)
    ) uf_decoder_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            fail_run();
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // chain decoder grows, clusters over full edges and repeats while a cluster is odd
    function automatic int decode_reference(input logic [PU_COUNT-1:0] syn,
                                            output logic [PU_COUNT:0] erasure);
        int   growth [PU_COUNT+1];
        logic odd [PU_COUNT];
        int   iterations;
        int   first;
        int   last;
        logic parity;
        logic flag;
        logic any_odd;
        for (int e = 0; e <= PU_COUNT; e++)
            growth[e] = 0;
        for (int i = 0; i < PU_COUNT; i++)
            odd[i] = syn[i]; // lone defects start odd
        iterations = 0;
        do begin
            iterations++;
            for (int e = 0; e <= PU_COUNT; e++) begin
                if (e > 0)
                    growth[e] += int'(odd[e-1]);
                if (e < PU_COUNT)
                    growth[e] += int'(odd[e]);
                if (growth[e] > 2)
                    growth[e] = 2;
            end
            any_odd = 1'b0;
            first = 0;
            while (first < PU_COUNT) begin
                last = first;
                parity = syn[first];
                while (last < PU_COUNT - 1 && growth[last+1] == 2) begin
                    last++;
                    parity ^= syn[last];
                end
                flag = parity && !(first == 0 && growth[0] == 2)
                       && !(last == PU_COUNT - 1 && growth[PU_COUNT] == 2);
                for (int i = first; i <= last; i++)
                    odd[i] = flag;
                any_odd |= flag;
                first = last + 1;
            end
        end while (any_odd);
        for (int e = 0; e <= PU_COUNT; e++)
            erasure[e] = (growth[e] == 2);
        return iterations;
    endfunction

    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] data,
                                output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk); // mid access phase
        rdata = prdata;
        err   = pslverr;
        check_value("pready", 32'(pready), 32'h1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_transfer(1'b1, addr, data, unused, err);
        check_value("pslverr", 32'(err), 32'h0);
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_transfer(1'b0, addr, 32'h0, data, err);
        check_value("pslverr", 32'(err), 32'h0);
    endtask

    task automatic start_round(input logic [PU_COUNT-1:0] syn);
        write_reg(REG_SYNDROME, 32'(syn));
        write_reg(REG_CTRL, 32'h1);
    endtask

    task automatic finish_round(input logic [PU_COUNT-1:0] syn);
        logic [PU_COUNT:0] exp_erasure;
        logic [31:0]       value;
        int                exp_iterations;
        int                min_cycles;
        exp_iterations = decode_reference(syn, exp_erasure);
        value = '0;
        while (!value[1])
            read_reg(REG_STATUS, value);
        check_value("status", value, 32'h2);
        read_reg(REG_ITERATIONS, value);
        check_value("iteration_counter", value, 32'(exp_iterations));
        read_reg(REG_ERASURE, value);
        check_value("erasure", value, 32'(exp_erasure));
        // loading and result, plus grow and the shortest merge per iteration
        min_cycles = exp_iterations * (MAXIMUM_DELAY + 2) + 2;
        read_reg(REG_CYCLES, value);
        if (value < 32'(min_cycles)) begin
            $display("FAILED cycle_counter: got 0x%08h, expected at least 0x%08h",
                     value, 32'(min_cycles));
            fail_run();
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: decoding rounds did not finish in time");
        fail_run();
    end

    initial begin
        logic [31:0] value;
        logic        err;
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        lcg_state = 32'h4598_a3f1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk);
        check_value("prdata", prdata, 32'h0);
        read_reg(REG_STATUS, value);
        check_value("status", value, 32'h0);
        read_reg(REG_ITERATIONS, value);
        check_value("iteration_counter", value, 32'h0);
        read_reg(REG_CYCLES, value);
        check_value("cycle_counter", value, 32'h0);
        read_reg(REG_ERASURE, value);
        check_value("erasure", value, 32'h0);

        start_round('0);
        finish_round('0);
        read_reg(REG_ITERATIONS, value);
        check_value("iteration_counter", value, 32'h1);

        // boundary neighbors, adjacent pair, distant pair
        start_round(18'h00001);
        finish_round(18'h00001);
        start_round(18'h20000);
        finish_round(18'h20000);
        start_round(18'h00300);
        finish_round(18'h00300);
        start_round(18'h02010);
        finish_round(18'h02010);

        for (int n = 0; n < 40; n++) begin
            value = next_random();
            start_round(value[31:14]); // upper LCG bits have the longer period
            finish_round(value[31:14]);
        end

        start_round(18'h00100);
        read_reg(REG_STATUS, value);
        check_value("status_busy", 32'(value[0]), 32'h1);
        write_reg(REG_SYNDROME, 32'h3ffff);
        finish_round(18'h00100);
        read_reg(REG_SYNDROME, value);
        check_value("syndrome", value, 32'h00100);

        start_round(18'h00400);
        write_reg(REG_CTRL, 32'h1);
        finish_round(18'h00400);
        repeat (5) @(posedge clk);
        read_reg(REG_STATUS, value);
        check_value("status", value, 32'h2);

        apb_transfer(1'b0, 8'h18, 32'h0, value, err);
        check_value("pslverr", 32'(err), 32'h1);
        check_value("prdata", value, 32'h0);

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- files.f
rtl/uf_pkg.sv
rtl/uf_processing_unit.sv
rtl/uf_pu_array.sv
rtl/uf_controller.sv
rtl/uf_apb_regs.sv
rtl/uf_decoder_top.sv
dv/uf_decoder_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f files.f \
    --top-module uf_decoder_tb \
    -o uf_decoder_sim

# the simulator exit code is masked by tee, the log decides
./obj_dir/uf_decoder_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
